/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = rvdiv_tb
FLIST     = rvdiv.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

# build, run, then scan the log for the failure line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)
	$(BUILD)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if grep -q "Something failed" $(LOG) || [ $$rc -ne 0 ]; then \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* rvdiv.f */
source/rvdiv_pkg.sv
source/div_decode.sv
source/div_cell.sv
source/div_array.sv
source/div_result.sv
source/rvdiv_top.sv
verif/rvdiv_asserts.sv
verif/rvdiv_tb.sv

/* source/div_array.sv */
`timescale 1ns/1ps

module div_array (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  req_valid,
    input  rvdiv_pkg::div_stage_t req,
    output logic                  res_valid,
    output rvdiv_pkg::div_stage_t res
);

    // index 0 is the array input, index XLEN the last cell output
    logic                  stage_vld [0:rvdiv_pkg::XLEN];
    rvdiv_pkg::div_stage_t stage_dat [0:rvdiv_pkg::XLEN];

    assign stage_vld[0] = req_valid;
    assign stage_dat[0] = req;

    // one quotient bit per cell, msb first
    for (genvar i = 0; i < rvdiv_pkg::XLEN; i++) begin : g_stage
        div_cell u_cell (
            .clk  (clk),
            .rstn (rstn),
            .en   (stage_vld[i]),
            .cin  (stage_dat[i]),
            .rdy  (stage_vld[i+1]),
            .cout (stage_dat[i+1])
        );
    end

    // after the last cell quo and rem are the unsigned results
    assign res_valid = stage_vld[rvdiv_pkg::XLEN];
    assign res       = stage_dat[rvdiv_pkg::XLEN];

endmodule

/* source/div_cell.sv */
`timescale 1ns/1ps

module div_cell (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  en,
    input  rvdiv_pkg::div_stage_t cin,
    output logic                  rdy,
    output rvdiv_pkg::div_stage_t cout
);

    // one extra bit so the shifted remainder cannot overflow
    logic [rvdiv_pkg::XLEN:0]   rem_sh;
    logic [rvdiv_pkg::XLEN:0]   rem_sub;
    logic                       ge;
    rvdiv_pkg::div_stage_t      cell_nxt;

    // bring down the next dividend bit
    assign rem_sh  = {cin.rem, cin.dvd[rvdiv_pkg::XLEN-1]};
    assign rem_sub = rem_sh - {1'b0, cin.dvs};
    assign ge      = (rem_sh >= {1'b0, cin.dvs});

    always_comb begin
        cell_nxt      = cin;   // dvs and side pass straight through
        // a zero divisor always subtracts, so quo fills with ones
        cell_nxt.rem  = ge ? rem_sub[rvdiv_pkg::XLEN-1:0]
                           : rem_sh[rvdiv_pkg::XLEN-1:0];
        cell_nxt.quo  = {cin.quo[rvdiv_pkg::XLEN-2:0], ge};
        cell_nxt.dvd  = {cin.dvd[rvdiv_pkg::XLEN-2:0], 1'b0};
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rdy  <= 1'b0;
            cout <= '0;
        end else begin
            rdy <= en;
            if (en) begin
                cout <= cell_nxt;   // hold when the slot is empty
            end
        end
    end

endmodule

/* source/div_decode.sv */
`timescale 1ns/1ps

module div_decode (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           in_valid,
    input  rvdiv_pkg::instr_u              in_instr,
    input  logic [rvdiv_pkg::XLEN-1:0]     in_rs1,
    input  logic [rvdiv_pkg::XLEN-1:0]     in_rs2,
    input  logic [rvdiv_pkg::TAG_W-1:0]    in_tag,
    output logic                           req_valid,
    output rvdiv_pkg::div_stage_t          req
);

    logic                       is_div;
    logic                       is_signed;
    logic                       rs1_neg;
    logic                       rs2_neg;
    logic [rvdiv_pkg::XLEN-1:0] rs1_mag;
    logic [rvdiv_pkg::XLEN-1:0] rs2_mag;
    logic                       zero_dvs;
    rvdiv_pkg::div_stage_t      req_nxt;

    // DIV/DIVU/REM/REMU all have funct3[2] set, MUL group has it clear
    assign is_div = (in_instr.r.opcode == rvdiv_pkg::OPC_OP)
                 && (in_instr.r.funct7 == rvdiv_pkg::F7_MULDIV)
                 && in_instr.r.funct3[2];

    // funct3[0] clear means the signed form
    assign is_signed = (in_instr.r.funct3 == rvdiv_pkg::F3_DIV)
                    || (in_instr.r.funct3 == rvdiv_pkg::F3_REM);

    assign rs1_neg = is_signed & in_rs1[rvdiv_pkg::XLEN-1];
    assign rs2_neg = is_signed & in_rs2[rvdiv_pkg::XLEN-1];

    // two's complement magnitudes, 0x80000000 maps onto itself
    assign rs1_mag = rs1_neg ? (~in_rs1 + 1'b1) : in_rs1;
    assign rs2_mag = rs2_neg ? (~in_rs2 + 1'b1) : in_rs2;

    assign zero_dvs = (in_rs2 == '0);

    always_comb begin
        req_nxt               = '0;   // rem and quo start at zero
        req_nxt.dvd           = rs1_mag;
        req_nxt.dvs           = rs2_mag;
        req_nxt.side.is_rem   = (in_instr.r.funct3 == rvdiv_pkg::F3_REM)
                             || (in_instr.r.funct3 == rvdiv_pkg::F3_REMU);
        // leave the all-ones quotient alone on divide by zero
        req_nxt.side.quo_neg  = (rs1_neg ^ rs2_neg) & ~zero_dvs;
        req_nxt.side.rem_neg  = rs1_neg;   // remainder follows dividend sign
        req_nxt.side.div_zero = zero_dvs;
        req_nxt.side.tag      = in_tag;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            req_valid <= 1'b0;
            req       <= '0;
        end else begin
            req_valid <= in_valid & is_div;   // anything else is dropped here
            if (in_valid && is_div) begin
                req <= req_nxt;
            end
        end
    end

endmodule

/* source/div_result.sv */
`timescale 1ns/1ps

module div_result (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           res_valid,
    input  rvdiv_pkg::div_stage_t          res,
    output logic                           out_valid,
    output logic [rvdiv_pkg::XLEN-1:0]     out_result,
    output logic [rvdiv_pkg::TAG_W-1:0]    out_tag
);

    logic [rvdiv_pkg::XLEN-1:0] quo_fix;
    logic [rvdiv_pkg::XLEN-1:0] rem_fix;
    logic [rvdiv_pkg::XLEN-1:0] result_nxt;

    // quo_neg is already cleared by decode on divide by zero
    assign quo_fix = res.side.quo_neg ? (~res.quo + 1'b1) : res.quo;
    assign rem_fix = res.side.rem_neg ? (~res.rem + 1'b1) : res.rem;

    // overflow case lands here as 0x80000000 / rem 0 with no extra logic
    assign result_nxt = res.side.is_rem ? rem_fix : quo_fix;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid  <= 1'b0;
            out_result <= '0;
            out_tag    <= '0;
        end else begin
            out_valid <= res_valid;
            if (res_valid) begin
                out_result <= result_nxt;
                out_tag    <= res.side.tag;
            end
        end
    end

endmodule

/* source/rvdiv_pkg.sv */
package rvdiv_pkg;

    // datapath and side-band widths
    localparam int XLEN    = 32;
    localparam int TAG_W   = 5;
    // decode + 32 array stages + result register
    localparam int DIV_LAT = 34;

    // register-register major opcode
    localparam logic [6:0] OPC_OP    = 7'b0110011;
    // funct7 shared by all M-extension ops
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    // divide group funct3 codes, bit 2 always set
    localparam logic [2:0] F3_DIV    = 3'b100;
    localparam logic [2:0] F3_DIVU   = 3'b101;
    localparam logic [2:0] F3_REM    = 3'b110;
    localparam logic [2:0] F3_REMU   = 3'b111;

    // R-type field layout, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rtype_t;

    // one instruction word, seen raw or split into fields
    typedef union packed {
        logic [31:0] raw;
        rtype_t      r;
    } instr_u;

    // bits that ride along with each operation
    typedef struct packed {
        logic             is_rem;    // return remainder instead of quotient
        logic             quo_neg;   // negate quotient at the end
        logic             rem_neg;   // negate remainder at the end
        logic             div_zero;  // divisor was zero
        logic [TAG_W-1:0] tag;       // destination tag
    } div_side_t;

    // word handed from one divider stage to the next
    typedef struct packed {
        logic [XLEN-1:0] rem;   // partial remainder
        logic [XLEN-1:0] quo;   // quotient bits so far
        logic [XLEN-1:0] dvd;   // dividend bits not yet consumed, msb first
        logic [XLEN-1:0] dvs;   // divisor magnitude
        div_side_t       side;
    } div_stage_t;

endpackage

/* source/rvdiv_top.sv */
`timescale 1ns/1ps

module rvdiv_top (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           in_valid,
    input  rvdiv_pkg::instr_u              in_instr,
    input  logic [rvdiv_pkg::XLEN-1:0]     in_rs1,
    input  logic [rvdiv_pkg::XLEN-1:0]     in_rs2,
    input  logic [rvdiv_pkg::TAG_W-1:0]    in_tag,
    output logic                           out_valid,
    output logic [rvdiv_pkg::XLEN-1:0]     out_result,
    output logic [rvdiv_pkg::TAG_W-1:0]    out_tag
);

    logic                  req_valid;
    rvdiv_pkg::div_stage_t req;
    logic                  res_valid;
    rvdiv_pkg::div_stage_t res;

    // decode and magnitude conversion, 1 cycle
    div_decode u_decode (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .in_rs1    (in_rs1),
        .in_rs2    (in_rs2),
        .in_tag    (in_tag),
        .req_valid (req_valid),
        .req       (req)
    );

    // 32 restoring stages
    div_array u_array (
        .clk       (clk),
        .rstn      (rstn),
        .req_valid (req_valid),
        .req       (req),
        .res_valid (res_valid),
        .res       (res)
    );

    // sign fix and output register, 1 cycle
    div_result u_result (
        .clk        (clk),
        .rstn       (rstn),
        .res_valid  (res_valid),
        .res        (res),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_tag    (out_tag)
    );

endmodule

/* verif/rvdiv_asserts.sv */
`timescale 1ns/1ps

module rvdiv_asserts (
    input logic                       clk,
    input logic                       rstn,
    input logic                       in_valid,
    input rvdiv_pkg::instr_u          in_instr,
    input logic                       out_valid,
    input logic [rvdiv_pkg::XLEN-1:0] out_result
);

    logic f3_div;
    logic qual;

    assign f3_div = (in_instr.r.funct3 == rvdiv_pkg::F3_DIV)
                 || (in_instr.r.funct3 == rvdiv_pkg::F3_DIVU)
                 || (in_instr.r.funct3 == rvdiv_pkg::F3_REM)
                 || (in_instr.r.funct3 == rvdiv_pkg::F3_REMU);

    // strobe that the unit has to accept
    assign qual = in_valid
               && (in_instr.r.opcode == rvdiv_pkg::OPC_OP)
               && (in_instr.r.funct7 == rvdiv_pkg::F7_MULDIV)
               && f3_div;

    // quiet in reset and on the first edge out of it
    reset_quiet: assert property (@(posedge clk)
        (!rstn || $past(!rstn)) |-> !out_valid)
        else $error("out_valid high during or right after reset");

    latency_fixed: assert property (@(posedge clk) disable iff (!rstn)
        $past(qual, rvdiv_pkg::DIV_LAT) |-> out_valid)
        else $error("accepted divide did not return after the fixed latency");

    no_spurious: assert property (@(posedge clk) disable iff (!rstn)
        out_valid |-> $past(qual, rvdiv_pkg::DIV_LAT))
        else $error("out_valid without a matching input strobe");

    result_known: assert property (@(posedge clk) disable iff (!rstn)
        out_valid |-> !$isunknown(out_result))
        else $error("out_result has unknown bits while valid");

endmodule

bind rvdiv_top rvdiv_asserts u_asserts (
    .clk        (clk),
    .rstn       (rstn),
    .in_valid   (in_valid),
    .in_instr   (in_instr),
    .out_valid  (out_valid),
    .out_result (out_result)
);

/* verif/rvdiv_tb.sv */
`timescale 1ns/1ps

module rvdiv_tb;

    logic                           clk = 1'b0;
    logic                           rstn;
    logic                           in_valid;
    rvdiv_pkg::instr_u              in_instr;
    logic [rvdiv_pkg::XLEN-1:0]     in_rs1;
    logic [rvdiv_pkg::XLEN-1:0]     in_rs2;
    logic [rvdiv_pkg::TAG_W-1:0]    in_tag;
    logic                           out_valid;
    logic [rvdiv_pkg::XLEN-1:0]     out_result;
    logic [rvdiv_pkg::TAG_W-1:0]    out_tag;

    // expected results in issue order
    logic [rvdiv_pkg::XLEN-1:0]     exp_result [256];
    logic [rvdiv_pkg::TAG_W-1:0]    exp_tag [256];
    logic [7:0]                     wr_ptr = 8'd0;
    logic [7:0]                     rd_ptr = 8'd0;
    logic [rvdiv_pkg::TAG_W-1:0]    next_tag = '0;

    rvdiv_top u_rvdiv_top (
        .clk        (clk),
        .rstn       (rstn),
        .in_valid   (in_valid),
        .in_instr   (in_instr),
        .in_rs1     (in_rs1),
        .in_rs2     (in_rs2),
        .in_tag     (in_tag),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_tag    (out_tag)
    );

    always #2 clk = ~clk;   // 4 ns period

    // pop on the edge after the strobe, checks below sample on the falling edge
    always @(posedge clk) begin
        if (out_valid) begin
            rd_ptr <= rd_ptr + 8'd1;
        end
    end

    chk_pending: assert property (@(negedge clk) disable iff (!rstn)
        out_valid |-> (rd_ptr != wr_ptr))
    else begin
        $display("output strobe arrived with no operation outstanding");
        $display("Something failed");
        $fatal(1);
    end

    chk_result: assert property (@(negedge clk) disable iff (!rstn)
        out_valid |-> (out_result == exp_result[rd_ptr]))
    else begin
        $display("[ERROR] out_result expected %h got %h", exp_result[rd_ptr], out_result);
        $display("Something failed");
        $fatal(1);
    end

    chk_tag: assert property (@(negedge clk) disable iff (!rstn)
        out_valid |-> (out_tag == exp_tag[rd_ptr]))
    else begin
        $display("[ERROR] out_tag expected %h got %h", exp_tag[rd_ptr], out_tag);
        $display("Something failed");
        $fatal(1);
    end

    // ISA results, including divide by zero and signed overflow
    function automatic logic [rvdiv_pkg::XLEN-1:0] ref_div(
        input logic [2:0]                 f3,
        input logic [rvdiv_pkg::XLEN-1:0] a,
        input logic [rvdiv_pkg::XLEN-1:0] b
    );
        logic                              ovf;
        logic signed [rvdiv_pkg::XLEN-1:0] sq;
        logic signed [rvdiv_pkg::XLEN-1:0] sr;
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        sq  = '0;
        sr  = '0;
        if ((b != '0) && !ovf) begin
            sq = $signed(a) / $signed(b);
            sr = $signed(a) % $signed(b);
        end
        case (f3)
            rvdiv_pkg::F3_DIV:  ref_div = (b == '0) ? '1 : (ovf ? a : sq);
            rvdiv_pkg::F3_DIVU: ref_div = (b == '0) ? '1 : a / b;
            rvdiv_pkg::F3_REM:  ref_div = (b == '0) ? a : (ovf ? '0 : sr);
            default:            ref_div = (b == '0) ? a : a % b;
        endcase
    endfunction

    function automatic logic [2:0] pick_f3(input logic [1:0] k);
        case (k)
            2'd0:    return rvdiv_pkg::F3_DIV;
            2'd1:    return rvdiv_pkg::F3_DIVU;
            2'd2:    return rvdiv_pkg::F3_REM;
            default: return rvdiv_pkg::F3_REMU;
        endcase
    endfunction

    function automatic rvdiv_pkg::instr_u make_instr(
        input logic [6:0] opcode,
        input logic [6:0] funct7,
        input logic [2:0] funct3
    );
        rvdiv_pkg::instr_u instr;
        instr.raw      = $urandom;   // random register fields
        instr.r.opcode = opcode;
        instr.r.funct7 = funct7;
        instr.r.funct3 = funct3;
        return instr;
    endfunction

    task automatic send_op(input logic [2:0] f3, input logic [31:0] a, input logic [31:0] b);
        @(posedge clk);
        in_valid <= 1'b1;
        in_instr <= make_instr(rvdiv_pkg::OPC_OP, rvdiv_pkg::F7_MULDIV, f3);
        in_rs1   <= a;
        in_rs2   <= b;
        in_tag   <= next_tag;
        exp_result[wr_ptr] = ref_div(f3, a, b);
        exp_tag[wr_ptr]    = next_tag;
        wr_ptr             = wr_ptr + 8'd1;
        next_tag           = next_tag + 5'd1;
    endtask

    task automatic send_other(input logic [6:0] opcode, input logic [6:0] funct7,
                              input logic [2:0] funct3);
        @(posedge clk);
        in_valid <= 1'b1;
        in_instr <= make_instr(opcode, funct7, funct3);
        in_rs1   <= $urandom;
        in_rs2   <= $urandom;
        in_tag   <= next_tag;   // must never come back
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        void'($urandom(32'hc33eb4d2));
        rstn     <= 1'b0;
        in_valid <= 1'b0;
        in_instr <= '0;
        in_rs1   <= '0;
        in_rs2   <= '0;
        in_tag   <= '0;
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        idle(4);

        // op in bits 1:0, operand signs in bits 3:2
        for (int i = 0; i < 96; i++) begin
            a = $urandom >> 5'($urandom);
            b = $urandom >> 5'($urandom);
            a = i[2] ? (~a + 32'd1) : a;
            b = i[3] ? (~b + 32'd1) : b;
            send_op(pick_f3(i[1:0]), a, b);
            idle(int'($urandom_range(2, 0)));
        end
        idle(10);

        for (int k = 0; k < 4; k++) begin
            send_op(pick_f3(2'(k)), $urandom, 32'h0);   // divide by zero
        end
        for (int k = 0; k < 4; k++) begin
            send_op(pick_f3(2'(k)), 32'h8000_0000, 32'hffff_ffff);
        end
        idle(rvdiv_pkg::DIV_LAT + 6);

        for (int i = 0; i < 40; i++) begin
            send_op(pick_f3(2'($urandom)), $urandom, $urandom >> 5'($urandom));
        end
        idle(5);

        for (int i = 0; i < 30; i++) begin
            case (i % 5)
                1:       send_other(7'b0010011, rvdiv_pkg::F7_MULDIV, 3'b100);   // OP-IMM
                3:       send_other(rvdiv_pkg::OPC_OP, 7'b0000000, 3'b100);      // XOR
                4:       send_other(rvdiv_pkg::OPC_OP, rvdiv_pkg::F7_MULDIV,
                                    {1'b0, 2'($urandom)});                        // MUL group
                default: send_op(pick_f3(2'($urandom)), $urandom, $urandom >> 5'($urandom));
            endcase
        end
        idle(2);

        wait (rd_ptr == wr_ptr);
        idle(rvdiv_pkg::DIV_LAT + 4);   // nothing may trail the last result
        if (rd_ptr == wr_ptr) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("result count does not match the issued operations");
            $display("Something failed");
            $fatal(1);
        end
    end

    initial begin
        int budget_cycles;
        // reset, random ops with gaps, special cases, burst, mixed stream, drain
        budget_cycles = 5 + 4 + 96 * 3 + 10 + 8 + 40 + 40 + 5 + 30 + 2
                      + 2 * rvdiv_pkg::DIV_LAT + 100;
        #(budget_cycles * 4);
        $display("watchdog timeout, results still outstanding");
        $display("Something failed");
        $fatal(1);
    end

endmodule
